//--- id_stage.f
common/isa_pkg.sv
common/ctrl_pkg.sv
decode/instr_decoder.sv
decode/operand_select.sv
hdl/reg_file.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
bench/id_stage_chk.sv
bench/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f id_stage.f \
    --top-module tb_id_stage \
    -o sim_id_stage

status=0
./obj_dir/sim_id_stage > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "run_sim: failure reported in sim.log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "run_sim: simulator exited with status $status"
    exit 1
fi

//--- bench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int TIMEOUT_NS = (NUM_TESTS * 200 + 8) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  id_valid;
    logic [XLEN-1:0]       id_instruction;
    logic [XLEN-1:0]       id_pc;
    logic                  wb_write_enable;
    logic [REG_ADDR_W-1:0] wb_dest_idx;
    logic [XLEN-1:0]       wb_data;
    logic                  ex_stall;
    logic                  pc_redirect;
    logic [XLEN-1:0]       pc_target;
    logic                  ex_valid;
    logic                  ex_write_enable;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    alu_op_e               ex_alu_op;
    logic [XLEN-1:0]       ex_operand_1;
    logic [XLEN-1:0]       ex_operand_2;
    logic [XLEN-1:0]       ex_store_data;
    logic [REG_ADDR_W-1:0] ex_dest_idx;

    // expected register contents
    logic [XLEN-1:0] model_regs [0:31];

    id_stage u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_valid        (id_valid),
        .id_instruction  (id_instruction),
        .id_pc           (id_pc),
        .wb_write_enable (wb_write_enable),
        .wb_dest_idx     (wb_dest_idx),
        .wb_data         (wb_data),
        .ex_stall        (ex_stall),
        .pc_redirect     (pc_redirect),
        .pc_target       (pc_target),
        .ex_valid        (ex_valid),
        .ex_write_enable (ex_write_enable),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .ex_alu_op       (ex_alu_op),
        .ex_operand_1    (ex_operand_1),
        .ex_operand_2    (ex_operand_2),
        .ex_store_data   (ex_store_data),
        .ex_dest_idx     (ex_dest_idx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    initial begin
        #(TIMEOUT_NS);
        fail_run("watchdog timeout: the tests did not finish in time");
    end

    task automatic compare_word(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                                input string what);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at %0d ns: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic compare_idx(input logic [REG_ADDR_W-1:0] actual,
                               input logic [REG_ADDR_W-1:0] expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at %0d ns: %s is %0d, expected %0d",
                               $time, what, actual, expected));
        end
    endtask

    task automatic compare_alu_op(input alu_op_e actual, input alu_op_e expected,
                                  input string what);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at %0d ns: %s is %s, expected %s",
                               $time, what, actual.name(), expected.name()));
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at %0d ns: %s is %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    // instruction encoders
    function automatic logic [XLEN-1:0] r_instr(input funct_e fn, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_instr(input opcode_e op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [XLEN-1:0] j_instr(input opcode_e op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic logic [XLEN-1:0] sign_ext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // every step ends 2 ns after a rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] idx, input logic [XLEN-1:0] data);
        wb_write_enable = 1'b1;
        wb_dest_idx     = idx;
        wb_data         = data;
        wait_cycle();
        wb_write_enable = 1'b0;
        if (idx != '0) begin
            model_regs[idx] = data;
        end
    endtask

    task automatic issue(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc,
                         input logic exp_redirect, input logic [XLEN-1:0] exp_target);
        id_valid       = 1'b1;
        id_instruction = instr;
        id_pc          = pc;
        #10;
        compare_bit(pc_redirect, exp_redirect, "pc_redirect");
        if (exp_redirect) begin
            compare_word(pc_target, exp_target, "pc_target");
        end
        wait_cycle();
        id_valid = 1'b0;
    endtask

    task automatic check_flags(input logic valid, input logic we, input logic mr, input logic mw);
        compare_bit(ex_valid, valid, "ex_valid");
        compare_bit(ex_write_enable, we, "ex_write_enable");
        compare_bit(ex_mem_read, mr, "ex_mem_read");
        compare_bit(ex_mem_write, mw, "ex_mem_write");
    endtask

    task automatic check_ex(input logic we, input logic mr, input logic mw, input alu_op_e op,
                            input logic [XLEN-1:0] op1, input logic [XLEN-1:0] op2,
                            input logic [XLEN-1:0] store, input logic [REG_ADDR_W-1:0] dest);
        check_flags(1'b1, we, mr, mw);
        compare_alu_op(ex_alu_op, op, "ex_alu_op");
        compare_word(ex_operand_1, op1, "ex_operand_1");
        compare_word(ex_operand_2, op2, "ex_operand_2");
        compare_word(ex_store_data, store, "ex_store_data");
        compare_idx(ex_dest_idx, dest, "ex_dest_idx");
    endtask

    task automatic after_reset();
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
        // a jump with no valid level must not redirect
        id_valid       = 1'b0;
        id_instruction = j_instr(OP_J, 26'h0000100);
        id_pc          = 32'h0000_0100;
        #10;
        compare_bit(pc_redirect, 1'b0, "pc_redirect");
        wait_cycle();
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic r_type_and_shifts();
        funct_e                fns [7];
        alu_op_e               ops [7];
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT};
        for (int i = 1; i < 32; i++) begin
            write_reg(REG_ADDR_W'(i), $urandom());
        end
        for (int k = 0; k < 7; k++) begin
            rs = REG_ADDR_W'(k + 1);
            rt = REG_ADDR_W'(k + 10);
            rd = REG_ADDR_W'(k + 20);
            issue(r_instr(fns[k], rs, rt, rd, 5'd0), 32'h0040_0000, 1'b0, '0);
            check_ex(1'b1, 1'b0, 1'b0, ops[k], model_regs[rs], model_regs[rt],
                     model_regs[rt], rd);
        end
        issue(r_instr(FN_SLL, 5'd0, 5'd14, 5'd27, 5'd7), 32'h0040_0004, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_SLL, model_regs[14], 32'd7, model_regs[14], 5'd27);
        issue(r_instr(FN_SRL, 5'd0, 5'd15, 5'd28, 5'd31), 32'h0040_0008, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_SRL, model_regs[15], 32'd31, model_regs[15], 5'd28);
    endtask

    task automatic immediates_and_memory();
        logic [15:0] neg;
        logic [15:0] pos;
        logic [15:0] zimm;
        logic [31:0] pc;
        neg  = 16'hff80;
        pos  = 16'h7ffe;
        zimm = 16'h8421;
        pc   = 32'h0040_0100;
        issue(i_instr(OP_ADDI, 5'd2, 5'd8, neg), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_ADD, model_regs[2], sign_ext(neg), model_regs[8], 5'd8);
        issue(i_instr(OP_SLTI, 5'd3, 5'd9, pos), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_SLT, model_regs[3], sign_ext(pos), model_regs[9], 5'd9);
        issue(i_instr(OP_LW, 5'd4, 5'd10, neg), pc, 1'b0, '0);
        check_ex(1'b1, 1'b1, 1'b0, ALU_ADD, model_regs[4], sign_ext(neg), model_regs[10], 5'd10);
        issue(i_instr(OP_SW, 5'd5, 5'd11, pos), pc, 1'b0, '0);
        check_ex(1'b0, 1'b0, 1'b1, ALU_ADD, model_regs[5], sign_ext(pos), model_regs[11], 5'd11);
        issue(i_instr(OP_ANDI, 5'd6, 5'd12, zimm), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_AND, model_regs[6], {16'h0, zimm}, model_regs[12], 5'd12);
        issue(i_instr(OP_ORI, 5'd7, 5'd13, zimm), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_OR, model_regs[7], {16'h0, zimm}, model_regs[13], 5'd13);
        issue(i_instr(OP_XORI, 5'd8, 5'd14, zimm), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_XOR, model_regs[8], {16'h0, zimm}, model_regs[14], 5'd14);
        issue(i_instr(OP_LUI, 5'd0, 5'd15, zimm), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_OR, 32'h0, {zimm, 16'h0}, model_regs[15], 5'd15);
    endtask

    task automatic branches_and_jumps();
        logic [31:0] pc;
        logic [31:0] pc_j;
        logic [31:0] jal_instr;
        logic [25:0] index;
        pc    = 32'h0040_1000;
        pc_j  = 32'ha000_0010;
        index = 26'h0123456;
        write_reg(5'd5, 32'h1357_9bdf);
        write_reg(5'd6, 32'h1357_9bdf);
        write_reg(5'd7, 32'h2468_ace0);
        write_reg(5'd9, 32'h0000_7f40);
        issue(i_instr(OP_BEQ, 5'd5, 5'd6, 16'hfff8), pc, 1'b1,
              pc + 32'd4 + (sign_ext(16'hfff8) << 2));
        check_flags(1'b1, 1'b0, 1'b0, 1'b0);
        issue(i_instr(OP_BEQ, 5'd5, 5'd7, 16'hfff8), pc, 1'b0, '0);
        issue(i_instr(OP_BNE, 5'd5, 5'd7, 16'h0010), pc, 1'b1,
              pc + 32'd4 + (sign_ext(16'h0010) << 2));
        issue(i_instr(OP_BNE, 5'd5, 5'd6, 16'h0010), pc, 1'b0, '0);
        // jump target keeps the top nibble of pc plus 4
        issue(j_instr(OP_J, index), pc_j, 1'b1, {4'ha, index, 2'b00});
        check_flags(1'b1, 1'b0, 1'b0, 1'b0);
        issue(r_instr(FN_JR, 5'd9, 5'd0, 5'd0, 5'd0), pc, 1'b1, model_regs[9]);
        check_flags(1'b1, 1'b0, 1'b0, 1'b0);
        jal_instr = j_instr(OP_JAL, index);
        issue(jal_instr, pc_j, 1'b1, {4'ha, index, 2'b00});
        check_ex(1'b1, 1'b0, 1'b0, ALU_ADD, pc_j, 32'd4, model_regs[jal_instr[20:16]], LINK_REG);
    endtask

    task automatic regs_illegal_and_stall();
        logic [31:0] pc;
        pc = 32'h0040_2000;
        write_reg(5'd0, 32'hdead_beef);
        issue(r_instr(FN_ADD, 5'd0, 5'd0, 5'd3, 5'd0), pc, 1'b0, '0);
        check_ex(1'b1, 1'b0, 1'b0, ALU_ADD, 32'h0, 32'h0, 32'h0, 5'd3);
        // write-back in the same cycle as the read
        wb_write_enable = 1'b1;
        wb_dest_idx     = 5'd12;
        wb_data         = 32'hcafe_f00d;
        issue(r_instr(FN_OR, 5'd12, 5'd12, 5'd4, 5'd0), pc, 1'b0, '0);
        wb_write_enable = 1'b0;
        model_regs[12]  = 32'hcafe_f00d;
        check_ex(1'b1, 1'b0, 1'b0, ALU_OR, model_regs[12], model_regs[12], model_regs[12], 5'd4);
        issue({6'h3f, 26'h0}, pc, 1'b0, '0);
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
        issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h01}, pc, 1'b0, '0);
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
        // held store differs from the waiting subtract in enables and fields
        issue(i_instr(OP_SW, 5'd1, 5'd2, 16'h0040), pc, 1'b0, '0);
        ex_stall       = 1'b1;
        id_valid       = 1'b1;
        id_instruction = r_instr(FN_SUB, 5'd3, 5'd4, 5'd6, 5'd0);
        id_pc          = pc + 32'd4;
        repeat (2) begin
            wait_cycle();
            check_ex(1'b0, 1'b0, 1'b1, ALU_ADD, model_regs[1], 32'h0000_0040, model_regs[2],
                     5'd2);
        end
        ex_stall = 1'b0;
        wait_cycle();
        id_valid = 1'b0;
        check_ex(1'b1, 1'b0, 1'b0, ALU_SUB, model_regs[3], model_regs[4], model_regs[4], 5'd6);
    endtask

    initial begin
        void'($urandom(32'h649cd6cd));
        rst_n           = 1'b0;
        id_valid        = 1'b0;
        id_instruction  = '0;
        id_pc           = '0;
        wb_write_enable = 1'b0;
        wb_dest_idx     = '0;
        wb_data         = '0;
        ex_stall        = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        after_reset();
        r_type_and_shifts();
        immediates_and_memory();
        branches_and_jumps();
        regs_illegal_and_stall();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           id_valid,
    input logic                           ex_stall,
    input logic                           pc_redirect,
    input logic                           ex_valid,
    input logic                           ex_write_enable,
    input logic                           ex_mem_read,
    input logic                           ex_mem_write,
    input ctrl_pkg::alu_op_e              ex_alu_op,
    input logic [isa_pkg::XLEN-1:0]       ex_operand_1,
    input logic [isa_pkg::XLEN-1:0]       ex_operand_2,
    input logic [isa_pkg::XLEN-1:0]       ex_store_data,
    input logic [isa_pkg::REG_ADDR_W-1:0] ex_dest_idx
);

    // set once a valid instruction could have been loaded
    logic seen_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_valid <= 1'b0;
        end else if (id_valid && !ex_stall) begin
            seen_valid <= 1'b1;
        end
    end

    mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem_read && ex_mem_write))
        else $error("ex_mem_read and ex_mem_write high together");

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        ex_stall |=> $stable({ex_valid, ex_write_enable, ex_mem_read, ex_mem_write, ex_alu_op,
                              ex_operand_1, ex_operand_2, ex_store_data, ex_dest_idx}))
        else $error("ex_ outputs changed while stalled");

    redirect_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pc_redirect |-> id_valid)
        else $error("pc_redirect without id_valid");

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_valid |-> !ex_valid)
        else $error("ex_valid high before any valid instruction");

endmodule

bind id_stage id_stage_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_valid        (id_valid),
    .ex_stall        (ex_stall),
    .pc_redirect     (pc_redirect),
    .ex_valid        (ex_valid),
    .ex_write_enable (ex_write_enable),
    .ex_mem_read     (ex_mem_read),
    .ex_mem_write    (ex_mem_write),
    .ex_alu_op       (ex_alu_op),
    .ex_operand_1    (ex_operand_1),
    .ex_operand_2    (ex_operand_2),
    .ex_store_data   (ex_store_data),
    .ex_dest_idx     (ex_dest_idx)
);

`default_nettype wire

//--- hdl/id_stage.sv
`default_nettype none
`timescale 1ns/1ps

module id_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           id_valid,
    input  logic [isa_pkg::XLEN-1:0]       id_instruction,
    input  logic [isa_pkg::XLEN-1:0]       id_pc,
    input  logic                           wb_write_enable,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wb_dest_idx,
    input  logic [isa_pkg::XLEN-1:0]       wb_data,
    input  logic                           ex_stall,
    output logic                           pc_redirect,
    output logic [isa_pkg::XLEN-1:0]       pc_target,
    output logic                           ex_valid,
    output logic                           ex_write_enable,
    output logic                           ex_mem_read,
    output logic                           ex_mem_write,
    output ctrl_pkg::alu_op_e              ex_alu_op,
    output logic [isa_pkg::XLEN-1:0]       ex_operand_1,
    output logic [isa_pkg::XLEN-1:0]       ex_operand_2,
    output logic [isa_pkg::XLEN-1:0]       ex_store_data,
    output logic [isa_pkg::REG_ADDR_W-1:0] ex_dest_idx
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    // decoder outputs
    alu_op_e      decoder_alu_op;
    instr_class_e decoder_instr_class;
    cond_e        decoder_cond;
    logic         decoder_is_jal;
    logic         decoder_write_enable;
    logic         decoder_mem_read;
    logic         decoder_mem_write;
    logic         decoder_illegal;

    logic [XLEN-1:0]       reg_file_rs_data;
    logic [XLEN-1:0]       reg_file_rt_data;
    logic [XLEN-1:0]       select_operand_1;
    logic [XLEN-1:0]       select_operand_2;
    logic [REG_ADDR_W-1:0] select_dest_idx;

    instr_decoder instr_decoder (
        .id_instruction (id_instruction),
        .alu_op         (decoder_alu_op),
        .instr_class    (decoder_instr_class),
        .cond           (decoder_cond),
        .is_jal         (decoder_is_jal),
        .write_enable   (decoder_write_enable),
        .mem_read       (decoder_mem_read),
        .mem_write      (decoder_mem_write),
        .illegal        (decoder_illegal)
    );

    // rs at [25:21], rt at [20:16]
    reg_file reg_file (
        .clk             (clk),
        .rst_n           (rst_n),
        .rs_idx          (id_instruction[25:21]),
        .rt_idx          (id_instruction[20:16]),
        .wb_write_enable (wb_write_enable),
        .wb_dest_idx     (wb_dest_idx),
        .wb_data         (wb_data),
        .rs_data         (reg_file_rs_data),
        .rt_data         (reg_file_rt_data)
    );

    operand_select operand_select (
        .instr_class    (decoder_instr_class),
        .cond           (decoder_cond),
        .is_jal         (decoder_is_jal),
        .illegal        (decoder_illegal),
        .id_valid       (id_valid),
        .id_instruction (id_instruction),
        .id_pc          (id_pc),
        .rs_data        (reg_file_rs_data),
        .rt_data        (reg_file_rt_data),
        .operand_1      (select_operand_1),
        .operand_2      (select_operand_2),
        .dest_idx       (select_dest_idx),
        .pc_redirect    (pc_redirect),
        .pc_target      (pc_target)
    );

    id_ex_reg id_ex_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_stall        (ex_stall),
        .id_valid        (id_valid),
        .illegal         (decoder_illegal),
        .alu_op          (decoder_alu_op),
        .write_enable    (decoder_write_enable),
        .mem_read        (decoder_mem_read),
        .mem_write       (decoder_mem_write),
        .operand_1       (select_operand_1),
        .operand_2       (select_operand_2),
        .store_data      (reg_file_rt_data),
        .dest_idx        (select_dest_idx),
        .ex_valid        (ex_valid),
        .ex_write_enable (ex_write_enable),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .ex_alu_op       (ex_alu_op),
        .ex_operand_1    (ex_operand_1),
        .ex_operand_2    (ex_operand_2),
        .ex_store_data   (ex_store_data),
        .ex_dest_idx     (ex_dest_idx)
    );

endmodule

`default_nettype wire

//--- hdl/id_ex_reg.sv
`default_nettype none
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ex_stall,
    input  logic                           id_valid,
    input  logic                           illegal,
    input  ctrl_pkg::alu_op_e              alu_op,
    input  logic                           write_enable,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [isa_pkg::XLEN-1:0]       operand_1,
    input  logic [isa_pkg::XLEN-1:0]       operand_2,
    input  logic [isa_pkg::XLEN-1:0]       store_data,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dest_idx,
    output logic                           ex_valid,
    output logic                           ex_write_enable,
    output logic                           ex_mem_read,
    output logic                           ex_mem_write,
    output ctrl_pkg::alu_op_e              ex_alu_op,
    output logic [isa_pkg::XLEN-1:0]       ex_operand_1,
    output logic [isa_pkg::XLEN-1:0]       ex_operand_2,
    output logic [isa_pkg::XLEN-1:0]       ex_store_data,
    output logic [isa_pkg::REG_ADDR_W-1:0] ex_dest_idx
);

    logic load_live;

    // bubble when the slot is empty or the code is illegal
    assign load_live = id_valid && !illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid        <= 1'b0;
            ex_write_enable <= 1'b0;
            ex_mem_read     <= 1'b0;
            ex_mem_write    <= 1'b0;
        end else if (!ex_stall) begin
            ex_valid        <= load_live;
            ex_write_enable <= load_live && write_enable;
            ex_mem_read     <= load_live && mem_read;
            ex_mem_write    <= load_live && mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_stall) begin
            ex_alu_op     <= alu_op;
            ex_operand_1  <= operand_1;
            ex_operand_2  <= operand_2;
            ex_store_data <= store_data;
            ex_dest_idx   <= dest_idx;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs_idx,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rt_idx,
    input  logic                           wb_write_enable,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wb_dest_idx,
    input  logic [isa_pkg::XLEN-1:0]       wb_data,
    output logic [isa_pkg::XLEN-1:0]       rs_data,
    output logic [isa_pkg::XLEN-1:0]       rt_data
);
    import isa_pkg::*;

    localparam int REG_COUNT = 1 << REG_ADDR_W;

    // register 0 has no storage
    logic [XLEN-1:0] regs [1:REG_COUNT-1];
    logic            wb_active;

    assign wb_active = wb_write_enable && (wb_dest_idx != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[wb_dest_idx] <= wb_data;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb_active && idx == wb_dest_idx) begin
            // write-back lands this cycle
            value = wb_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

endmodule

`default_nettype wire

//--- decode/operand_select.sv
`default_nettype none
`timescale 1ns/1ps

module operand_select (
    input  ctrl_pkg::instr_class_e         instr_class,
    input  ctrl_pkg::cond_e                cond,
    input  logic                           is_jal,
    input  logic                           illegal,
    input  logic                           id_valid,
    input  logic [isa_pkg::XLEN-1:0]       id_instruction,
    input  logic [isa_pkg::XLEN-1:0]       id_pc,
    input  logic [isa_pkg::XLEN-1:0]       rs_data,
    input  logic [isa_pkg::XLEN-1:0]       rt_data,
    output logic [isa_pkg::XLEN-1:0]       operand_1,
    output logic [isa_pkg::XLEN-1:0]       operand_2,
    output logic [isa_pkg::REG_ADDR_W-1:0] dest_idx,
    output logic                           pc_redirect,
    output logic [isa_pkg::XLEN-1:0]       pc_target
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [REG_ADDR_W-1:0] rt_idx;
    logic [REG_ADDR_W-1:0] rd_idx;
    logic [SHAMT_W-1:0]    shamt;
    logic [IMM_W-1:0]      imm;
    logic [J_INDEX_W-1:0]  j_index;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       pc_plus_4;
    logic [XLEN-1:0]       branch_target;
    logic [XLEN-1:0]       jump_target;
    logic                  operands_equal;
    logic                  taken;

    assign rt_idx  = id_instruction[20:16];
    assign rd_idx  = id_instruction[15:11];
    assign shamt   = id_instruction[10:6];
    assign imm     = id_instruction[IMM_W-1:0];
    assign j_index = id_instruction[J_INDEX_W-1:0];

    assign imm_sext      = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign imm_zext      = {{(XLEN-IMM_W){1'b0}}, imm};
    assign pc_plus_4     = id_pc + XLEN'(4);
    assign branch_target = pc_plus_4 + {imm_sext[XLEN-3:0], 2'b00};
    // top nibble comes from the next sequential pc
    assign jump_target   = {pc_plus_4[XLEN-1:XLEN-4], j_index, 2'b00};

    always_comb begin
        operand_1 = rs_data;
        operand_2 = rt_data;
        dest_idx  = rt_idx;
        case (instr_class)
            CLS_R: dest_idx = rd_idx;
            CLS_SHIFT: begin
                operand_1 = rt_data;
                operand_2 = {{(XLEN-SHAMT_W){1'b0}}, shamt};
                dest_idx  = rd_idx;
            end
            CLS_IMM_S: operand_2 = imm_sext;
            CLS_IMM_Z: operand_2 = imm_zext;
            CLS_LUI: begin
                operand_1 = '0;
                operand_2 = {imm, {(XLEN-IMM_W){1'b0}}};
            end
            // execute adds these into the link value
            CLS_JUMP: begin
                operand_1 = id_pc;
                operand_2 = XLEN'(4);
                dest_idx  = is_jal ? LINK_REG : '0;
            end
            default: ;
        endcase
    end

    assign operands_equal = (rs_data == rt_data);

    always_comb begin
        taken     = 1'b0;
        pc_target = branch_target;
        case (instr_class)
            CLS_BRANCH: begin
                taken = (cond == COND_EQ && operands_equal)
                     || (cond == COND_NE && !operands_equal);
            end
            CLS_JUMP: begin
                taken     = 1'b1;
                pc_target = jump_target;
            end
            CLS_JR: begin
                taken     = 1'b1;
                pc_target = rs_data;
            end
            default: ;
        endcase
    end

    // empty slot or illegal code never redirects
    assign pc_redirect = id_valid && !illegal && taken;

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
    input  logic [isa_pkg::XLEN-1:0] id_instruction,
    output ctrl_pkg::alu_op_e        alu_op,
    output ctrl_pkg::instr_class_e   instr_class,
    output ctrl_pkg::cond_e          cond,
    output logic                     is_jal,
    output logic                     write_enable,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     illegal
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(id_instruction[XLEN-1:XLEN-OPCODE_W]);
    assign funct  = funct_e'(id_instruction[FUNCT_W-1:0]);

    always_comb begin
        alu_op       = ALU_ADD;
        instr_class  = CLS_R;
        cond         = COND_NONE;
        is_jal       = 1'b0;
        write_enable = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        illegal      = 1'b0;

        case (opcode)
            R_TYPE: begin
                write_enable = 1'b1;
                case (funct)
                    FN_ADD: alu_op = ALU_ADD;
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR:  alu_op = ALU_OR;
                    FN_XOR: alu_op = ALU_XOR;
                    FN_NOR: alu_op = ALU_NOR;
                    FN_SLT: alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op      = ALU_SLL;
                        instr_class = CLS_SHIFT;
                    end
                    FN_SRL: begin
                        alu_op      = ALU_SRL;
                        instr_class = CLS_SHIFT;
                    end
                    FN_JR: begin
                        instr_class  = CLS_JR;
                        write_enable = 1'b0;
                    end
                    default: begin
                        illegal      = 1'b1;
                        write_enable = 1'b0;
                    end
                endcase
            end
            OP_ADDI: begin
                instr_class  = CLS_IMM_S;
                write_enable = 1'b1;
            end
            OP_SLTI: begin
                alu_op       = ALU_SLT;
                instr_class  = CLS_IMM_S;
                write_enable = 1'b1;
            end
            OP_ANDI: begin
                alu_op       = ALU_AND;
                instr_class  = CLS_IMM_Z;
                write_enable = 1'b1;
            end
            OP_ORI: begin
                alu_op       = ALU_OR;
                instr_class  = CLS_IMM_Z;
                write_enable = 1'b1;
            end
            OP_XORI: begin
                alu_op       = ALU_XOR;
                instr_class  = CLS_IMM_Z;
                write_enable = 1'b1;
            end
            // zero or'ed with the shifted immediate
            OP_LUI: begin
                alu_op       = ALU_OR;
                instr_class  = CLS_LUI;
                write_enable = 1'b1;
            end
            OP_LW: begin
                instr_class  = CLS_IMM_S;
                write_enable = 1'b1;
                mem_read     = 1'b1;
            end
            OP_SW: begin
                instr_class = CLS_IMM_S;
                mem_write   = 1'b1;
            end
            OP_BEQ: begin
                alu_op      = ALU_SUB;
                instr_class = CLS_BRANCH;
                cond        = COND_EQ;
            end
            OP_BNE: begin
                alu_op      = ALU_SUB;
                instr_class = CLS_BRANCH;
                cond        = COND_NE;
            end
            OP_J: instr_class = CLS_JUMP;
            // link value is pc plus 4, formed in execute
            OP_JAL: begin
                instr_class  = CLS_JUMP;
                is_jal       = 1'b1;
                write_enable = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // operation handed to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        COND_NONE,
        COND_EQ,
        COND_NE
    } cond_e;

    // how operands, destination and redirect are routed
    typedef enum logic [2:0] {
        CLS_R,
        CLS_SHIFT,
        CLS_IMM_S,
        CLS_IMM_Z,
        CLS_LUI,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_JR
    } instr_class_e;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;
    localparam int J_INDEX_W  = 26;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;

    // return address register for jal
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef enum logic [OPCODE_W-1:0] {
        R_TYPE  = 6'h00,
        OP_J    = 6'h02,
        OP_JAL  = 6'h03,
        OP_BEQ  = 6'h04,
        OP_BNE  = 6'h05,
        OP_ADDI = 6'h08,
        OP_SLTI = 6'h0a,
        OP_ANDI = 6'h0c,
        OP_ORI  = 6'h0d,
        OP_XORI = 6'h0e,
        OP_LUI  = 6'h0f,
        OP_LW   = 6'h23,
        OP_SW   = 6'h2b
    } opcode_e;

    // only meaningful when opcode is R_TYPE
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2a
    } funct_e;

endpackage

`default_nettype wire
